// File: all.f
+incdir+verilog
verilog/clint_pkg.sv
verilog/clint_axi_slave.sv
verilog/clint_regs.sv
verilog/clint.sv
sim/clint_checker.sv
sim/tb_clint.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the CLINT testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -f all.f --top-module tb_clint -Mdir "$BUILD" -o tb_clint
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/tb_clint" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

// File: sim/clint_checker.sv
// CLINT response checker

`include "clint_macros.svh"

module clint_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i,
  input  logic                 b_valid_i, b_ready_i, ar_valid_i, ar_ready_i,
  input  logic                 r_valid_i, r_ready_i, r_last_i, soft_irq_i, timer_irq_i,
  input  clint_pkg::addr_t     aw_addr_i, ar_addr_i,
  input  clint_pkg::data_t     w_data_i, r_data_i,
  input  clint_pkg::strb_t     w_strb_i,
  input  clint_pkg::resp_t     b_resp_i, r_resp_i,
  input  clint_pkg::axi_id_t   aw_id_i, b_id_i, ar_id_i, r_id_i,
  input  clint_pkg::axi_user_t aw_user_i, b_user_i, ar_user_i, r_user_i,
  input  int                   test_idx_i,
  input  logic                 test_done_i,
  output int                   err_count_o,
  output int                   tests_failed_o
);

  localparam int TAG_W = `CLINT_ID_W + `CLINT_USER_W;

  // register model, holds the state after the coming edge
  logic [31:0]      m_msip;
  clint_pkg::data_t m_mtimecmp;
  clint_pkg::data_t m_mtime;

  clint_pkg::addr_t wr_addr;
  logic [TAG_W-1:0] wr_tag;
  clint_pkg::data_t rd_exp_q[$];
  logic [TAG_W-1:0] rd_tag_q[$];
  logic [TAG_W-1:0] b_tag_q[$];

  // write channel progress
  logic wr_busy;
  logic wr_open;

  int test_errs  = 0;
  int err_total  = 0;
  int fail_total = 0;

  assign err_count_o    = err_total + test_errs;
  assign tests_failed_o = fail_total;

  function automatic string test_name(int idx);
    case (idx)
      1: return "reset_values";
      2: return "strobe_merge";
      3: return "soft_irq";
      4: return "timer_irq";
      5: return "backpressure";
      6: return "unmapped_read";
      default: return "idle";
    endcase
  endfunction

  function automatic clint_pkg::data_t merge_bytes(clint_pkg::data_t old_val,
                                                   clint_pkg::data_t new_val,
                                                   clint_pkg::strb_t strb);
    clint_pkg::data_t res;
    res = old_val;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // expected read data from the register map
  function automatic clint_pkg::data_t clint_expect(clint_pkg::addr_t addr, logic [31:0] msip,
                                                    clint_pkg::data_t mtimecmp,
                                                    clint_pkg::data_t mtime);
    case (addr)
      `CLINT_MSIP_ADDR:     return {{32{msip[31]}}, msip};
      `CLINT_MTIMECMP_ADDR: return mtimecmp;
      `CLINT_MTIME_ADDR:    return mtime;
      default:              return '0;
    endcase
  endfunction

  task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] test %s: %s expected %h actual %h", test_name(test_idx_i), what,
               exp, act);
      test_errs++;
    end
  endtask

  task automatic report_fault(string msg);
    $display("[ERROR] test %s: %s", test_name(test_idx_i), msg);
    test_errs++;
  endtask

  // negedge sampling, handshakes seen here complete on the next rising edge
  always @(negedge clk) begin
    clint_pkg::data_t tmp;
    logic             wr_hit;
    if (rst) begin
      m_msip     = '0;
      m_mtimecmp = `CLINT_MTIMECMP_RST;
      m_mtime    = '0;
      wr_busy    = 1'b0;
      wr_open    = 1'b0;
      rd_exp_q.delete();
      rd_tag_q.delete();
      b_tag_q.delete();
    end else begin
      check_value("soft_irq", 64'(m_msip[0]), 64'(soft_irq_i));
      check_value("timer_irq", 64'(m_mtime >= m_mtimecmp), 64'(timer_irq_i));
      // channel flow from the outstanding requests
      check_value("ar_ready", 64'(ar_valid_i && rd_exp_q.size() == 0), 64'(ar_ready_i));
      check_value("r_valid", 64'(rd_exp_q.size() != 0), 64'(r_valid_i));
      check_value("aw_ready", 64'(aw_valid_i && !wr_busy), 64'(aw_ready_i));
      check_value("w_ready", 64'(wr_open), 64'(w_ready_i));
      check_value("b_valid", 64'(b_tag_q.size() != 0), 64'(b_valid_i));
      if (r_valid_i && r_ready_i) begin
        if (rd_exp_q.size() == 0) begin
          report_fault("read data returned with no read pending");
        end else begin
          check_value("r_data", rd_exp_q.pop_front(), r_data_i);
          check_value("r_user/id", 64'(rd_tag_q.pop_front()), 64'({r_user_i, r_id_i}));
          check_value("r_resp", 64'(`CLINT_RESP_OKAY), 64'(r_resp_i));
          check_value("r_last", 64'd1, 64'(r_last_i));
        end
      end
      if (b_valid_i && b_ready_i) begin
        wr_busy = 1'b0;
        if (b_tag_q.size() == 0) begin
          report_fault("write response returned with no write pending");
        end else begin
          check_value("b_user/id", 64'(b_tag_q.pop_front()), 64'({b_user_i, b_id_i}));
          check_value("b_resp", 64'(`CLINT_RESP_OKAY), 64'(b_resp_i));
        end
      end
      // read value is the one before this edge
      if (ar_valid_i && ar_ready_i) begin
        rd_exp_q.push_back(clint_expect(ar_addr_i, m_msip, m_mtimecmp, m_mtime));
        rd_tag_q.push_back({ar_user_i, ar_id_i});
      end
      if (aw_valid_i && aw_ready_i) begin
        wr_addr = aw_addr_i;
        wr_tag  = {aw_user_i, aw_id_i};
        wr_busy = 1'b1;
        wr_open = 1'b1;
      end
      wr_hit = w_valid_i && w_ready_i;
      if (wr_hit && w_last_i) begin
        b_tag_q.push_back(wr_tag);
        wr_open = 1'b0;
      end
      if (wr_hit && wr_addr == `CLINT_MSIP_ADDR) begin
        tmp    = merge_bytes({32'h0, m_msip}, w_data_i, w_strb_i);
        m_msip = tmp[31:0];
      end
      if (wr_hit && wr_addr == `CLINT_MTIMECMP_ADDR) begin
        m_mtimecmp = merge_bytes(m_mtimecmp, w_data_i, w_strb_i);
      end
      if (wr_hit && wr_addr == `CLINT_MTIME_ADDR) begin
        m_mtime = merge_bytes(m_mtime, w_data_i, w_strb_i);
      end else begin
        m_mtime = m_mtime + 64'd1;
      end
    end
    if (test_done_i) begin
      if (rd_exp_q.size() != 0) begin
        report_fault("read response missing at end of test");
      end
      if (b_tag_q.size() != 0) begin
        report_fault("write response missing at end of test");
      end
      $display("test %0d %s: %s", test_idx_i, test_name(test_idx_i),
               test_errs == 0 ? "ok" : "FAILED");
      if (test_errs != 0) begin
        fail_total++;
      end
      err_total += test_errs;
      test_errs = 0;
    end
  end

endmodule

// File: sim/tb_clint.sv
// CLINT testbench

`include "clint_macros.svh"

module tb_clint;

  localparam int NUM_TESTS = 6;

  logic clk = 1'b0;
  logic rst = 1'b1;

  logic                 aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  logic                 b_valid_o, b_ready_i, ar_valid_i, ar_ready_o;
  logic                 r_valid_o, r_ready_i, r_last_o, soft_irq_o, timer_irq_o;
  clint_pkg::addr_t     aw_addr_i, ar_addr_i;
  clint_pkg::data_t     w_data_i, r_data_o;
  clint_pkg::strb_t     w_strb_i;
  clint_pkg::resp_t     b_resp_o, r_resp_o;
  clint_pkg::axi_id_t   aw_id_i, b_id_o, ar_id_i, r_id_o;
  clint_pkg::axi_user_t aw_user_i, b_user_o, ar_user_i, r_user_o;

  int   seed = 81056;
  int   test_idx = 0;
  logic test_done = 1'b0;
  logic backpressure = 1'b0;
  int   err_count;
  int   tests_failed;

  always #5 clk = ~clk;

  clint u_dut (.*);

  clint_checker u_checker (
    .clk (clk), .rst (rst),
    .aw_valid_i (aw_valid_i), .aw_ready_i (aw_ready_o), .aw_addr_i (aw_addr_i),
    .aw_id_i (aw_id_i), .aw_user_i (aw_user_i),
    .w_valid_i (w_valid_i), .w_ready_i (w_ready_o), .w_data_i (w_data_i),
    .w_strb_i (w_strb_i), .w_last_i (w_last_i),
    .b_valid_i (b_valid_o), .b_ready_i (b_ready_i), .b_resp_i (b_resp_o),
    .b_id_i (b_id_o), .b_user_i (b_user_o),
    .ar_valid_i (ar_valid_i), .ar_ready_i (ar_ready_o), .ar_addr_i (ar_addr_i),
    .ar_id_i (ar_id_i), .ar_user_i (ar_user_i),
    .r_valid_i (r_valid_o), .r_ready_i (r_ready_i), .r_data_i (r_data_o),
    .r_resp_i (r_resp_o), .r_last_i (r_last_o), .r_id_i (r_id_o), .r_user_i (r_user_o),
    .soft_irq_i (soft_irq_o), .timer_irq_i (timer_irq_o),
    .test_idx_i (test_idx), .test_done_i (test_done),
    .err_count_o (err_count), .tests_failed_o (tests_failed)
  );

  // rnd supplies id, user and the response hold-off
  task automatic axi_write(clint_pkg::addr_t addr, clint_pkg::data_t data,
                           clint_pkg::strb_t strb, int beats, logic [31:0] rnd);
    int hold;
    hold = backpressure ? int'(rnd[10:8]) : 0;
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = rnd[`CLINT_ID_W-1:0];
    aw_user_i  = rnd[`CLINT_ID_W +: `CLINT_USER_W];
    @(negedge clk);
    while (!aw_ready_o) @(negedge clk);
    @(posedge clk);
    #1;
    aw_valid_i = 1'b0;
    for (int k = 0; k < beats; k++) begin
      w_valid_i = 1'b1;
      w_data_i  = data + 64'(k) * 64'h0101_0101_0101_0101;
      w_strb_i  = (strb << (k % 8)) | (strb >> (8 - k % 8));
      w_last_i  = (k == beats - 1);
      @(negedge clk);
      while (!w_ready_o) @(negedge clk);
      @(posedge clk);
      #1;
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    repeat (hold) @(posedge clk);
    #1;
    b_ready_i = 1'b1;
    @(negedge clk);
    while (!b_valid_o) @(negedge clk);
    @(posedge clk);
    #1;
    b_ready_i = 1'b0;
  endtask

  task automatic axi_read(clint_pkg::addr_t addr, logic [31:0] rnd);
    int hold;
    hold = backpressure ? int'(rnd[10:8]) : 0;
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = rnd[`CLINT_ID_W-1:0];
    ar_user_i  = rnd[`CLINT_ID_W +: `CLINT_USER_W];
    @(negedge clk);
    while (!ar_ready_o) @(negedge clk);
    @(posedge clk);
    #1;
    ar_valid_i = 1'b0;
    repeat (hold) @(posedge clk);
    #1;
    r_ready_i = 1'b1;
    @(negedge clk);
    while (!r_valid_o) @(negedge clk);
    @(posedge clk);
    #1;
    r_ready_i = 1'b0;
  endtask

  task automatic finish_test();
    test_done = 1'b1;
    @(posedge clk);
    #1;
    test_done = 1'b0;
  endtask

  initial begin
    logic [31:0] wr_rnd;
    logic [31:0] rd_rnd;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    aw_user_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    ar_user_i  = '0;
    r_ready_i  = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    test_idx = 1;
    repeat (7) @(posedge clk);
    #1;
    axi_read(`CLINT_MSIP_ADDR, $random(seed));
    axi_read(`CLINT_MTIMECMP_ADDR, $random(seed));
    axi_read(`CLINT_MTIME_ADDR, $random(seed));
    finish_test();

    test_idx = 2;
    axi_write(`CLINT_MTIMECMP_ADDR, 64'h0123_4567_89AB_CDEF, 8'h0F, 1, $random(seed));
    axi_write(`CLINT_MTIMECMP_ADDR, 64'h1122_3344_5566_7788, 8'hA5, 3, $random(seed));
    axi_write(`CLINT_MTIME_ADDR, 64'h0000_0000_0055_AA00, 8'h06, 2, $random(seed));
    axi_read(`CLINT_MTIMECMP_ADDR, $random(seed));
    axi_read(`CLINT_MTIME_ADDR, $random(seed));
    finish_test();

    test_idx = 3;
    axi_write(`CLINT_MSIP_ADDR, 64'h0000_0000_8000_0001, 8'h0F, 1, $random(seed));
    axi_read(`CLINT_MSIP_ADDR, $random(seed));
    axi_write(`CLINT_MSIP_ADDR, 64'hFFFF_FFFF_0000_0000, 8'hF0, 1, $random(seed));
    axi_write(`CLINT_MSIP_ADDR, 64'h0, 8'h01, 1, $random(seed));
    axi_read(`CLINT_MSIP_ADDR, $random(seed));
    finish_test();

    // compare value a few dozen cycles ahead of mtime
    test_idx = 4;
    axi_write(`CLINT_MTIME_ADDR, 64'd1000, 8'hFF, 1, $random(seed));
    axi_write(`CLINT_MTIMECMP_ADDR, 64'd1040, 8'hFF, 1, $random(seed));
    repeat (50) @(posedge clk);
    #1;
    axi_read(`CLINT_MTIME_ADDR, $random(seed));
    axi_write(`CLINT_MTIME_ADDR, 64'd0, 8'hFF, 1, $random(seed));
    repeat (5) @(posedge clk);
    #1;
    finish_test();

    test_idx = 5;
    backpressure = 1'b1;
    for (int i = 0; i < 8; i++) begin
      wr_rnd = $random(seed);
      rd_rnd = $random(seed);
      fork
        axi_write(`CLINT_MTIMECMP_ADDR, {wr_rnd, rd_rnd}, wr_rnd[23:16], 1 + i % 3, wr_rnd);
        axi_read(i % 3 == 0 ? `CLINT_MSIP_ADDR :
                 i % 3 == 1 ? `CLINT_MTIMECMP_ADDR : `CLINT_MTIME_ADDR, rd_rnd);
      join
    end
    backpressure = 1'b0;
    finish_test();

    test_idx = 6;
    axi_read(64'h0000_0000_0200_1000, $random(seed));
    axi_read(64'h0000_0000_0200_BFF0, $random(seed));
    finish_test();

    repeat (2) @(posedge clk);
    $display("tests run: %0d, tests failed: %0d, errors: %0d", NUM_TESTS, tests_failed,
             err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_TESTS * 2000);
    $display("timeout: DUT stopped responding during test %0d", test_idx);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: verilog/clint.sv
// CLINT top level

module clint (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  clint_pkg::addr_t     aw_addr_i,
  input  clint_pkg::axi_id_t   aw_id_i,
  input  clint_pkg::axi_user_t aw_user_i,

  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  clint_pkg::data_t     w_data_i,
  input  clint_pkg::strb_t     w_strb_i,
  input  logic                 w_last_i,

  input  logic                 b_ready_i,
  output logic                 b_valid_o,
  output clint_pkg::resp_t     b_resp_o,
  output clint_pkg::axi_id_t   b_id_o,
  output clint_pkg::axi_user_t b_user_o,

  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  clint_pkg::addr_t     ar_addr_i,
  input  clint_pkg::axi_id_t   ar_id_i,
  input  clint_pkg::axi_user_t ar_user_i,

  input  logic                 r_ready_i,
  output logic                 r_valid_o,
  output clint_pkg::data_t     r_data_o,
  output clint_pkg::resp_t     r_resp_o,
  output logic                 r_last_o,
  output clint_pkg::axi_id_t   r_id_o,
  output clint_pkg::axi_user_t r_user_o,

  // interrupt levels to the core
  output logic                 soft_irq_o,
  output logic                 timer_irq_o
);

  logic             reg_wr_en;
  clint_pkg::addr_t reg_wr_addr;
  clint_pkg::data_t reg_wr_data;
  clint_pkg::strb_t reg_wr_strb;
  logic             reg_rd_en;
  clint_pkg::addr_t reg_rd_addr;
  clint_pkg::data_t reg_rd_data;

  clint_axi_slave u_axi_slave (
    .clk           (clk),
    .rst           (rst),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_o    (aw_ready_o),
    .aw_addr_i     (aw_addr_i),
    .aw_id_i       (aw_id_i),
    .aw_user_i     (aw_user_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_last_i      (w_last_i),
    .b_ready_i     (b_ready_i),
    .b_valid_o     (b_valid_o),
    .b_resp_o      (b_resp_o),
    .b_id_o        (b_id_o),
    .b_user_o      (b_user_o),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .ar_addr_i     (ar_addr_i),
    .ar_id_i       (ar_id_i),
    .ar_user_i     (ar_user_i),
    .r_ready_i     (r_ready_i),
    .r_valid_o     (r_valid_o),
    .r_data_o      (r_data_o),
    .r_resp_o      (r_resp_o),
    .r_last_o      (r_last_o),
    .r_id_o        (r_id_o),
    .r_user_o      (r_user_o),
    .reg_wr_en_o   (reg_wr_en),
    .reg_wr_addr_o (reg_wr_addr),
    .reg_wr_data_o (reg_wr_data),
    .reg_wr_strb_o (reg_wr_strb),
    .reg_rd_en_o   (reg_rd_en),
    .reg_rd_addr_o (reg_rd_addr),
    .reg_rd_data_i (reg_rd_data)
  );

  clint_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (reg_wr_en),
    .wr_addr_i   (reg_wr_addr),
    .wr_data_i   (reg_wr_data),
    .wr_strb_i   (reg_wr_strb),
    .rd_en_i     (reg_rd_en),
    .rd_addr_i   (reg_rd_addr),
    .rd_data_o   (reg_rd_data),
    .soft_irq_o  (soft_irq_o),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// File: verilog/clint_axi_slave.sv
// CLINT AXI4 slave port

`include "clint_macros.svh"

module clint_axi_slave (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  clint_pkg::addr_t     aw_addr_i,
  input  clint_pkg::axi_id_t   aw_id_i,
  input  clint_pkg::axi_user_t aw_user_i,

  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  clint_pkg::data_t     w_data_i,
  input  clint_pkg::strb_t     w_strb_i,
  input  logic                 w_last_i,

  input  logic                 b_ready_i,
  output logic                 b_valid_o,
  output clint_pkg::resp_t     b_resp_o,
  output clint_pkg::axi_id_t   b_id_o,
  output clint_pkg::axi_user_t b_user_o,

  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  clint_pkg::addr_t     ar_addr_i,
  input  clint_pkg::axi_id_t   ar_id_i,
  input  clint_pkg::axi_user_t ar_user_i,

  input  logic                 r_ready_i,
  output logic                 r_valid_o,
  output clint_pkg::data_t     r_data_o,
  output clint_pkg::resp_t     r_resp_o,
  output logic                 r_last_o,
  output clint_pkg::axi_id_t   r_id_o,
  output clint_pkg::axi_user_t r_user_o,

  output logic                 reg_wr_en_o,
  output clint_pkg::addr_t     reg_wr_addr_o,
  output clint_pkg::data_t     reg_wr_data_o,
  output clint_pkg::strb_t     reg_wr_strb_o,
  output logic                 reg_rd_en_o,
  output clint_pkg::addr_t     reg_rd_addr_o,
  input  clint_pkg::data_t     reg_rd_data_i
);

  clint_pkg::rd_state_e rd_state;
  clint_pkg::wr_state_e wr_state;

  clint_pkg::addr_t     wr_addr_q;
  clint_pkg::axi_id_t   wr_id_q;
  clint_pkg::axi_user_t wr_user_q;

  clint_pkg::data_t     rd_data_q;
  clint_pkg::axi_id_t   rd_id_q;
  clint_pkg::axi_user_t rd_user_q;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // read channel, one request at a time
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= clint_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        clint_pkg::RD_IDLE: begin
          if (ar_hs) begin
            rd_state <= clint_pkg::RD_RESP;
          end
        end
        clint_pkg::RD_RESP: begin
          if (r_hs) begin
            rd_state <= clint_pkg::RD_IDLE;
          end
        end
        default: rd_state <= clint_pkg::RD_IDLE;
      endcase
    end
  end

  // data sampled in the handshake cycle, before mtime steps
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_data_q <= reg_rd_data_i;
      rd_id_q   <= ar_id_i;
      rd_user_q <= ar_user_i;
    end
  end

  // address ready only while idle and a request is offered
  assign ar_ready_o    = (rd_state == clint_pkg::RD_IDLE) && ar_valid_i;
  assign reg_rd_en_o   = ar_hs;
  assign reg_rd_addr_o = ar_addr_i;

  assign r_valid_o = (rd_state == clint_pkg::RD_RESP);
  assign r_data_o  = rd_data_q;
  assign r_resp_o  = `CLINT_RESP_OKAY;
  assign r_last_o  = 1'b1;
  assign r_id_o    = rd_id_q;
  assign r_user_o  = rd_user_q;

  // write channel, beats until w_last then one response
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= clint_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        clint_pkg::WR_IDLE: begin
          if (aw_hs) begin
            wr_state <= clint_pkg::WR_DATA;
          end
        end
        clint_pkg::WR_DATA: begin
          if (w_hs && w_last_i) begin
            wr_state <= clint_pkg::WR_RESP;
          end
        end
        clint_pkg::WR_RESP: begin
          if (b_hs) begin
            wr_state <= clint_pkg::WR_IDLE;
          end
        end
        default: wr_state <= clint_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_addr_q <= aw_addr_i;
      wr_id_q   <= aw_id_i;
      wr_user_q <= aw_user_i;
    end
  end

  assign aw_ready_o = (wr_state == clint_pkg::WR_IDLE) && aw_valid_i;
  assign w_ready_o  = (wr_state == clint_pkg::WR_DATA);

  // every beat goes to the same captured address
  assign reg_wr_en_o   = w_hs;
  assign reg_wr_addr_o = wr_addr_q;
  assign reg_wr_data_o = w_data_i;
  assign reg_wr_strb_o = w_strb_i;

  assign b_valid_o = (wr_state == clint_pkg::WR_RESP);
  assign b_resp_o  = `CLINT_RESP_OKAY;
  assign b_id_o    = wr_id_q;
  assign b_user_o  = wr_user_q;

endmodule

// File: verilog/clint_macros.svh
// CLINT address map and constants

`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// register addresses, single hart layout
`define CLINT_MSIP_ADDR      64'h0000_0000_0200_0000
`define CLINT_MTIMECMP_ADDR  64'h0000_0000_0200_4000
`define CLINT_MTIME_ADDR     64'h0000_0000_0200_BFF8

// mtimecmp starts at the largest positive value so the timer irq stays low
`define CLINT_MTIMECMP_RST   64'h7FFF_FFFF_FFFF_FFFF

// bus widths
`define CLINT_ADDR_W         64
`define CLINT_DATA_W         64
`define CLINT_ID_W           4
`define CLINT_USER_W         1

// axi response code
`define CLINT_RESP_OKAY      2'b00

`endif

// File: verilog/clint_pkg.sv
// CLINT types

`include "clint_macros.svh"

package clint_pkg;

  typedef logic [`CLINT_ADDR_W-1:0]   addr_t;
  typedef logic [`CLINT_DATA_W-1:0]   data_t;
  typedef logic [`CLINT_DATA_W/8-1:0] strb_t;
  typedef logic [`CLINT_ID_W-1:0]     axi_id_t;
  typedef logic [`CLINT_USER_W-1:0]   axi_user_t;
  typedef logic [1:0]                 resp_t;

  // read channel
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  // write channel
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

endpackage

// File: verilog/clint_regs.sv
// CLINT register block

`include "clint_macros.svh"

module clint_regs (
  input  logic             clk,
  input  logic             rst,

  input  logic             wr_en_i,
  input  clint_pkg::addr_t wr_addr_i,
  input  clint_pkg::data_t wr_data_i,
  input  clint_pkg::strb_t wr_strb_i,
  input  logic             rd_en_i,
  input  clint_pkg::addr_t rd_addr_i,

  output clint_pkg::data_t rd_data_o,
  output logic             soft_irq_o,
  output logic             timer_irq_o
);

  logic [31:0]      msip;
  clint_pkg::data_t mtimecmp;
  clint_pkg::data_t mtime;

  clint_pkg::data_t wr_mask;
  clint_pkg::data_t msip_ext;

  logic msip_we;
  logic mtimecmp_we;
  logic mtime_we;

  logic msip_rd;
  logic mtimecmp_rd;
  logic mtime_rd;

  // expand byte strobes to a bit mask
  always_comb begin
    for (int i = 0; i < $bits(clint_pkg::strb_t); i++) begin
      wr_mask[i*8 +: 8] = {8{wr_strb_i[i]}};
    end
  end

  assign msip_we     = wr_en_i && (wr_addr_i == `CLINT_MSIP_ADDR);
  assign mtimecmp_we = wr_en_i && (wr_addr_i == `CLINT_MTIMECMP_ADDR);
  assign mtime_we    = wr_en_i && (wr_addr_i == `CLINT_MTIME_ADDR);

  // msip only holds the low word
  always_ff @(posedge clk) begin
    if (rst) begin
      msip <= '0;
    end else if (msip_we) begin
      msip <= (msip & ~wr_mask[31:0]) | (wr_data_i[31:0] & wr_mask[31:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp <= `CLINT_MTIMECMP_RST;
    end else if (mtimecmp_we) begin
      mtimecmp <= (mtimecmp & ~wr_mask) | (wr_data_i & wr_mask);
    end
  end

  // a write replaces this cycle's increment
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else if (mtime_we) begin
      mtime <= (mtime & ~wr_mask) | (wr_data_i & wr_mask);
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  assign msip_rd     = rd_addr_i == `CLINT_MSIP_ADDR;
  assign mtimecmp_rd = rd_addr_i == `CLINT_MTIMECMP_ADDR;
  assign mtime_rd    = rd_addr_i == `CLINT_MTIME_ADDR;

  assign msip_ext = {{32{msip[31]}}, msip};

  // unmapped addresses read as zero
  always_comb begin
    rd_data_o = '0;
    if (rd_en_i) begin
      if (msip_rd) begin
        rd_data_o = msip_ext;
      end else if (mtimecmp_rd) begin
        rd_data_o = mtimecmp;
      end else if (mtime_rd) begin
        rd_data_o = mtime;
      end
    end
  end

  assign soft_irq_o  = msip[0];
  assign timer_irq_o = (mtime >= mtimecmp);

endmodule
